//--- source/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// major opcodes, bits [6:0] of the instruction

// upper immediate, rd = imm_u
`define RV_OP_LUI    7'b0110111

// register-immediate arithmetic and shifts
`define RV_OP_IMM    7'b0010011

// register-register arithmetic
`define RV_OP_REG    7'b0110011

// loads, only the address is computed here
`define RV_OP_LOAD   7'b0000011

// stores, same
`define RV_OP_STORE  7'b0100011

// conditional branches, compare only
`define RV_OP_BRANCH 7'b1100011

// addi x0, x0, 0
// fed to the decoder on idle cycles
`define RV_BUBBLE    32'h0000_0013

// architectural register count, x0 included
`define RV_NUM_REGS  32

`endif

//--- source/rv_pkg.sv
package rv_pkg;

  // data word, also used for instructions
  typedef logic [31:0] word_t;

  // register index x0..x31
  typedef logic [4:0] reg_idx_t;

  // alu operations
  // ALU_ILL marks an undecodable instruction
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_ILL
  } alu_cmd_t;

  // second operand source
  typedef enum logic {REG, IMM} op_type_t;

  // match patterns for casez
  // layout funct7 / rs2 / rs1 / funct3 / rd / opcode

  // r-type
  localparam word_t ADD   = 32'b0000000_?????_?????_000_?????_0110011;
  localparam word_t SUB   = 32'b0100000_?????_?????_000_?????_0110011;
  localparam word_t SLL   = 32'b0000000_?????_?????_001_?????_0110011;
  localparam word_t SLT   = 32'b0000000_?????_?????_010_?????_0110011;
  localparam word_t SLTU  = 32'b0000000_?????_?????_011_?????_0110011;
  localparam word_t XOR   = 32'b0000000_?????_?????_100_?????_0110011;
  localparam word_t SRL   = 32'b0000000_?????_?????_101_?????_0110011;
  localparam word_t SRA   = 32'b0100000_?????_?????_101_?????_0110011;
  localparam word_t OR    = 32'b0000000_?????_?????_110_?????_0110011;
  localparam word_t AND   = 32'b0000000_?????_?????_111_?????_0110011;

  // i-type arithmetic, shifts keep funct7 in imm[11:5]
  localparam word_t ADDI  = 32'b???????_?????_?????_000_?????_0010011;
  localparam word_t SLTI  = 32'b???????_?????_?????_010_?????_0010011;
  localparam word_t SLTIU = 32'b???????_?????_?????_011_?????_0010011;
  localparam word_t XORI  = 32'b???????_?????_?????_100_?????_0010011;
  localparam word_t ORI   = 32'b???????_?????_?????_110_?????_0010011;
  localparam word_t ANDI  = 32'b???????_?????_?????_111_?????_0010011;
  localparam word_t SLLI  = 32'b0000000_?????_?????_001_?????_0010011;
  localparam word_t SRLI  = 32'b0000000_?????_?????_101_?????_0010011;
  localparam word_t SRAI  = 32'b0100000_?????_?????_101_?????_0010011;

  // upper immediate
  localparam word_t LUI   = 32'b???????_?????_?????_???_?????_0110111;

  // loads
  localparam word_t LB    = 32'b???????_?????_?????_000_?????_0000011;
  localparam word_t LH    = 32'b???????_?????_?????_001_?????_0000011;
  localparam word_t LW    = 32'b???????_?????_?????_010_?????_0000011;
  localparam word_t LBU   = 32'b???????_?????_?????_100_?????_0000011;
  localparam word_t LHU   = 32'b???????_?????_?????_101_?????_0000011;

  // stores
  localparam word_t SB    = 32'b???????_?????_?????_000_?????_0100011;
  localparam word_t SH    = 32'b???????_?????_?????_001_?????_0100011;
  localparam word_t SW    = 32'b???????_?????_?????_010_?????_0100011;

  // branches
  localparam word_t BEQ   = 32'b???????_?????_?????_000_?????_1100011;
  localparam word_t BNE   = 32'b???????_?????_?????_001_?????_1100011;
  localparam word_t BLT   = 32'b???????_?????_?????_100_?????_1100011;
  localparam word_t BGE   = 32'b???????_?????_?????_101_?????_1100011;
  localparam word_t BLTU  = 32'b???????_?????_?????_110_?????_1100011;
  localparam word_t BGEU  = 32'b???????_?????_?????_111_?????_1100011;

endpackage

//--- source/instr_decoder.sv
`include "rv_defs.svh"

module instr_decoder (
  input  rv_pkg::word_t    instruction,
  input  logic             instr_valid,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::alu_cmd_t alu_cmd,
  output rv_pkg::word_t    imm,
  output rv_pkg::op_type_t op2_type,
  output logic             reg_write
);
  import rv_pkg::*;

  // instruction actually decoded
  word_t      instr;
  logic [6:0] opcode;

  // idle cycles decode as a harmless addi
  assign instr  = instr_valid ? instruction : `RV_BUBBLE;
  assign opcode = instr[6:0];

  // register indices
  always_comb begin
    // lui adds imm_u to x0
    if (opcode == `RV_OP_LUI) begin
      rs1 = '0;
    end else begin
      rs1 = instr[19:15];
    end
    rs2 = instr[24:20];
    rd  = instr[11:7];
  end

  // operand b select
  always_comb begin
    case (opcode)
      `RV_OP_IMM, `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_LUI: begin
        op2_type = IMM;
      end
      // r-type and branches compare against rs2
      default: begin
        op2_type = REG;
      end
    endcase
  end

  // immediate formats
  always_comb begin
    case (opcode)
      // i-type, sign extended
      `RV_OP_IMM, `RV_OP_LOAD: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      // s-type, split field
      `RV_OP_STORE: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      // u-type, already shifted up by 12
      `RV_OP_LUI: begin
        imm = {instr[31:12], 12'h000};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

  // only arithmetic and lui retire into rd
  always_comb begin
    case (opcode)
      `RV_OP_REG, `RV_OP_IMM, `RV_OP_LUI: begin
        reg_write = 1'b1;
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

  // alu command from the full match patterns
  always_comb begin
    casez (instr)
      // address generation and lui go through the adder
      ADD, ADDI, LUI, LB, LH, LW, LBU, LHU, SB, SH, SW: begin
        alu_cmd = ALU_ADD;
      end
      SUB:          alu_cmd = ALU_SUB;
      XOR, XORI:    alu_cmd = ALU_XOR;
      OR, ORI:      alu_cmd = ALU_OR;
      AND, ANDI:    alu_cmd = ALU_AND;
      SLL, SLLI:    alu_cmd = ALU_SLL;
      SRL, SRLI:    alu_cmd = ALU_SRL;
      SRA, SRAI:    alu_cmd = ALU_SRA;
      SLT, SLTI:    alu_cmd = ALU_SLT;
      SLTU, SLTIU:  alu_cmd = ALU_SLTU;
      // branch conditions
      BEQ:          alu_cmd = ALU_EQ;
      BNE:          alu_cmd = ALU_NE;
      BLT:          alu_cmd = ALU_LT;
      BGE:          alu_cmd = ALU_GE;
      BLTU:         alu_cmd = ALU_LTU;
      BGEU:         alu_cmd = ALU_GEU;
      // anything else is flagged upstream
      default:      alu_cmd = ALU_ILL;
    endcase
  end

endmodule

//--- source/reg_file.sv
`include "rv_defs.svh"

module reg_file (
  input  logic             clk,
  input  logic             arst_n,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::word_t    wr_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  // x0..x31
  // entry 0 is cleared by reset and never written after
  word_t regs [`RV_NUM_REGS];

  // write port
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // every register reads zero out of reset
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      // writes to x0 are dropped here
      regs[wr_idx] <= wr_data;
    end
  end

  // read ports, combinational
  // a write at edge N is visible right after the edge
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- source/alu.sv
module alu (
  input  rv_pkg::alu_cmd_t alu_cmd,
  input  rv_pkg::word_t    op_a,
  input  rv_pkg::word_t    op_b,
  output rv_pkg::word_t    alu_out
);
  import rv_pkg::*;

  // shift amount, low five bits of b
  logic [4:0] shamt;

  // shared compare results
  logic lt_s;
  logic lt_u;
  logic eq;

  assign shamt = op_b[4:0];

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;
  assign eq   = (op_a == op_b);

  always_comb begin
    case (alu_cmd)
      // arithmetic
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;

      // logic
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;

      // shifts
      ALU_SLL:  alu_out = op_a << shamt;
      ALU_SRL:  alu_out = op_a >> shamt;
      // arithmetic right shift keeps the sign
      ALU_SRA:  alu_out = word_t'($signed(op_a) >>> shamt);

      // set less than, 0 or 1
      ALU_SLT:  alu_out = {31'b0, lt_s};
      ALU_SLTU: alu_out = {31'b0, lt_u};

      // branch conditions, 0 or 1
      ALU_EQ:   alu_out = {31'b0, eq};
      ALU_NE:   alu_out = {31'b0, !eq};
      ALU_LT:   alu_out = {31'b0, lt_s};
      ALU_GE:   alu_out = {31'b0, !lt_s};
      ALU_LTU:  alu_out = {31'b0, lt_u};
      ALU_GEU:  alu_out = {31'b0, !lt_u};

      // ALU_ILL and anything unlisted
      default:  alu_out = '0;
    endcase
  end

endmodule

//--- source/exec_core.sv
module exec_core (
  input  logic          clk,
  input  logic          arst_n,
  input  rv_pkg::word_t instruction,
  input  logic          instr_valid,
  output rv_pkg::word_t result,
  output logic          result_valid,
  output logic          illegal
);
  import rv_pkg::*;

  // decoder outputs
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  alu_cmd_t alu_cmd;
  word_t    imm;
  op_type_t op2_type;
  logic     reg_write;

  // datapath
  word_t rs1_data;
  word_t rs2_data;
  word_t op_b;
  word_t alu_out;

  // retire control
  logic cmd_legal;
  logic retire;
  logic wr_en;

  instr_decoder u_decoder (
    .instruction (instruction),
    .instr_valid (instr_valid),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .alu_cmd     (alu_cmd),
    .imm         (imm),
    .op2_type    (op2_type),
    .reg_write   (reg_write)
  );

  // write-back lands at the same edge that loads result
  reg_file u_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr_en    (wr_en),
    .wr_idx   (rd),
    .wr_data  (alu_out),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // operand b, rs2 or immediate
  assign op_b = (op2_type == IMM) ? imm : rs2_data;

  alu u_alu (
    .alu_cmd (alu_cmd),
    .op_a    (rs1_data),
    .op_b    (op_b),
    .alu_out (alu_out)
  );

  assign cmd_legal = (alu_cmd != ALU_ILL);
  assign retire    = instr_valid && cmd_legal;
  // loads, stores, branches retire without a write
  assign wr_en     = retire && reg_write;

  // one-cycle latency output stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result       <= '0;
      result_valid <= 1'b0;
      illegal      <= 1'b0;
    end else begin
      // result holds unless a legal instruction retires
      if (retire) begin
        result <= alu_out;
      end
      result_valid <= retire;
      illegal      <= instr_valid && !cmd_legal;
    end
  end

endmodule

//--- tests/exec_core_properties.sv
module exec_core_properties (
  input logic clk,
  input logic arst_n,
  input logic instr_valid,
  input logic result_valid,
  input logic illegal
);
  timeunit 1ns;
  timeprecision 100ps;

  // a retiring instruction is either legal or illegal
  a_flags_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(result_valid && illegal)
  ) else $error("result_valid and illegal are high in the same cycle");

  // flags only follow a valid instruction one cycle earlier
  a_flags_need_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    (result_valid || illegal) |-> $past(instr_valid)
  ) else $error("a flag is high without instr_valid in the previous cycle");

  // reset holds both flags low
  a_flags_low_in_reset: assert property (
    @(posedge clk)
    !arst_n |-> (!result_valid && !illegal)
  ) else $error("a flag is high while arst_n is low");

endmodule

bind exec_core exec_core_properties u_properties (
  .clk          (clk),
  .arst_n       (arst_n),
  .instr_valid  (instr_valid),
  .result_valid (result_valid),
  .illegal      (illegal)
);

//--- tests/exec_core_tb.sv
`include "rv_defs.svh"

module exec_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam int CLK_PERIOD = 8;

  // one table row with expected values worked out by hand
  typedef struct {
    word_t instr;
    word_t exp_result;
    logic  exp_valid;
    logic  exp_illegal;
  } entry_t;

  logic  clk;
  logic  arst_n;
  word_t instruction;
  logic  instr_valid;
  word_t result;
  logic  result_valid;
  logic  illegal;

  entry_t tbl [$];
  logic   tbl_ready;

  exec_core DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .instruction  (instruction),
    .instr_valid  (instr_valid),
    .result       (result),
    .result_valid (result_valid),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // rv32i encoders with arguments in assembly order
  function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
  endfunction

  function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  // offset +8 puts 01000 in bits [11:7] where the x8 field sits
  function automatic word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
    return {7'b0000000, rs2, rs1, f3, 5'b01000, `RV_OP_BRANCH};
  endfunction

  function automatic word_t enc_u(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  function automatic void push_valid(word_t instr, word_t exp_result);
    entry_t e;
    e.instr       = instr;
    e.exp_result  = exp_result;
    e.exp_valid   = 1'b1;
    e.exp_illegal = 1'b0;
    tbl.push_back(e);
  endfunction

  // result must keep the value it held before
  function automatic void push_illegal(word_t instr, word_t held_result);
    entry_t e;
    e.instr       = instr;
    e.exp_result  = held_result;
    e.exp_valid   = 1'b0;
    e.exp_illegal = 1'b1;
    tbl.push_back(e);
  endfunction

  function automatic void build_table();
    // register reset seen through x0 + 0
    push_valid(enc_i(`RV_OP_IMM, 3'b000, 5'd5, 5'd0, 12'h000), 32'h0000_0000);
    // lui and i-type arithmetic
    push_valid(enc_u(5'd1, 20'h12345), 32'h1234_5000);
    push_valid(enc_i(`RV_OP_IMM, 3'b000, 5'd2, 5'd1, 12'h678), 32'h1234_5678);
    push_valid(enc_i(`RV_OP_IMM, 3'b100, 5'd3, 5'd2, 12'hfff), 32'hedcb_a987);
    push_valid(enc_i(`RV_OP_IMM, 3'b110, 5'd4, 5'd1, 12'h0f0), 32'h1234_50f0);
    push_valid(enc_i(`RV_OP_IMM, 3'b111, 5'd5, 5'd2, 12'h0ff), 32'h0000_0078);
    push_valid(enc_i(`RV_OP_IMM, 3'b010, 5'd6, 5'd3, 12'h000), 32'h0000_0001);
    // -1 sign extends to all ones for the unsigned compare
    push_valid(enc_i(`RV_OP_IMM, 3'b011, 5'd7, 5'd2, 12'hfff), 32'h0000_0001);
    push_valid(enc_i(`RV_OP_IMM, 3'b001, 5'd8, 5'd2, 12'h004), 32'h2345_6780);
    push_valid(enc_i(`RV_OP_IMM, 3'b101, 5'd9, 5'd3, 12'h008), 32'h00ed_cba9);
    push_valid(enc_i(`RV_OP_IMM, 3'b101, 5'd10, 5'd3, 12'h408), 32'hffed_cba9);
    // the rs1 field of this lui selects x8 and must be ignored
    push_valid(enc_u(5'd18, 20'h12345), 32'h1234_5000);
    // r-type chained through write-back
    push_valid(enc_r(7'h00, 3'b000, 5'd11, 5'd2, 5'd1), 32'h2468_a678);
    push_valid(enc_r(7'h20, 3'b000, 5'd12, 5'd11, 5'd2), 32'h1234_5000);
    push_valid(enc_r(7'h00, 3'b010, 5'd13, 5'd3, 5'd12), 32'h0000_0001);
    push_valid(enc_r(7'h00, 3'b011, 5'd14, 5'd13, 5'd3), 32'h0000_0001);
    push_valid(enc_r(7'h00, 3'b001, 5'd15, 5'd12, 5'd14), 32'h2468_a000);
    push_valid(enc_r(7'h00, 3'b101, 5'd16, 5'd3, 5'd14), 32'h76e5_d4c3);
    push_valid(enc_r(7'h20, 3'b101, 5'd17, 5'd3, 5'd14), 32'hf6e5_d4c3);
    // x0 stays zero
    push_valid(enc_i(`RV_OP_IMM, 3'b000, 5'd0, 5'd0, 12'h005), 32'h0000_0005);
    push_valid(enc_r(7'h00, 3'b000, 5'd6, 5'd0, 5'd0), 32'h0000_0000);
    // address generation without a write to x20 or x28
    push_valid(enc_i(`RV_OP_LOAD, 3'b010, 5'd20, 5'd2, 12'h010), 32'h1234_5688);
    push_valid(enc_s(3'b010, 5'd3, 5'd2, 12'hffc), 32'h1234_5674);
    // branches where x1 equals x12 and x3 is negative
    push_valid(enc_b(3'b000, 5'd1, 5'd12), 32'h0000_0001);
    push_valid(enc_b(3'b001, 5'd1, 5'd12), 32'h0000_0000);
    push_valid(enc_b(3'b100, 5'd3, 5'd1), 32'h0000_0001);
    push_valid(enc_b(3'b101, 5'd3, 5'd1), 32'h0000_0000);
    push_valid(enc_b(3'b110, 5'd3, 5'd1), 32'h0000_0000);
    push_valid(enc_b(3'b111, 5'd3, 5'd1), 32'h0000_0001);
    // targets of the load, store and branches are untouched
    push_valid(enc_r(7'h00, 3'b000, 5'd21, 5'd20, 5'd0), 32'h0000_0000);
    push_valid(enc_r(7'h00, 3'b000, 5'd23, 5'd28, 5'd0), 32'h0000_0000);
    push_valid(enc_r(7'h00, 3'b000, 5'd22, 5'd8, 5'd0), 32'h2345_6780);
    // illegal words leave x31 and x2 alone
    push_illegal(32'hffff_ffff, 32'h2345_6780);
    push_valid(enc_r(7'h00, 3'b000, 5'd24, 5'd31, 5'd0), 32'h0000_0000);
    push_illegal(enc_r(7'h01, 3'b000, 5'd2, 5'd1, 5'd1), 32'h0000_0000);
    push_valid(enc_i(`RV_OP_IMM, 3'b000, 5'd25, 5'd2, 12'h000), 32'h1234_5678);
  endfunction

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // one entry cycle then one idle cycle between falling edges
  task automatic apply_entry(input entry_t e, input int idx);
    instruction = e.instr;
    instr_valid = 1'b1;
    @(negedge clk);
    check_word(result, e.exp_result, $sformatf("entry %0d result", idx));
    check_flag(result_valid, e.exp_valid, $sformatf("entry %0d result_valid", idx));
    check_flag(illegal, e.exp_illegal, $sformatf("entry %0d illegal", idx));
    instruction = `RV_BUBBLE;
    instr_valid = 1'b0;
    @(negedge clk);
    // result holds through the idle cycle with no flag
    check_word(result, e.exp_result, $sformatf("idle after %0d result", idx));
    check_flag(result_valid, 1'b0, $sformatf("idle after %0d result_valid", idx));
    check_flag(illegal, 1'b0, $sformatf("idle after %0d illegal", idx));
  endtask

  // two cycles per entry plus slack for reset
  initial begin
    wait (tbl_ready);
    #(CLK_PERIOD * (tbl.size() * 2 + 10));
    $display("the run timed out after %0d clock periods", tbl.size() * 2 + 10);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    tbl_ready   = 1'b0;
    arst_n      = 1'b0;
    instruction = `RV_BUBBLE;
    instr_valid = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // outputs straight out of reset
    @(negedge clk);
    check_word(result, 32'h0000_0000, "result after reset");
    check_flag(result_valid, 1'b0, "result_valid after reset");
    check_flag(illegal, 1'b0, "illegal after reset");
    for (int i = 0; i < tbl.size(); i++) begin
      apply_entry(tbl[i], i);
    end
    $display("Test OK");
    $finish;
  end

endmodule

//--- src.f
+incdir+source
source/rv_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/exec_core.sv
tests/exec_core_properties.sv
tests/exec_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the exec_core testbench with Verilator
# exit status is the simulator's, non-zero on any failure

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module exec_core_tb \
  -Mdir obj_dir \
  -f src.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vexec_core_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit "$sim_status"
fi

exit 0
